//--- all.f
hdl/rv_dm_pkg.sv
hdl/rv_dm_sync.sv
hdl/rv_dm_late_debug_reg.sv
hdl/rv_dm_en_ctrl.sv
hdl/rv_dm_ndm_tracker.sv
hdl/rv_dm_gate.sv
tests/tb_rv_dm_gate.sv

//--- Makefile
# Verilator flow for the debug-enable gate
# Override any variable on the command line, e.g. make sim LOG=run.log

SHELL := /bin/bash

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= tb_rv_dm_gate
RTL_TOP   ?= rv_dm_gate
BUILD_DIR ?= build
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert

BIN := $(BUILD_DIR)/V$(TB_TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(RTL_TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: $(BIN)
	set -o pipefail; $(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation finished without failure"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_rv_dm_gate.sv
////////////////////
// Testbench for the debug-enable gate
// Runs reset, enable selection, late-debug, write-lock and NDM ack tests
// Expected values follow the strict selection and ack rules of the gate
////////////////////

`default_nettype none

module tb_rv_dm_gate
  import rv_dm_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod    = 20;
  localparam int ResetCycles  = 16;
  localparam int SettleLen    = 4;
  localparam int RandomLen    = 24;
  localparam int WriteTimeout = 8;
  localparam int HoldLen      = 12;
  localparam int ReleaseLen   = 8;
  localparam int AckTimeout   = 24;
  // Sum of all test phases plus margin
  localparam int WatchdogCycles = ResetCycles + 8 * (SettleLen + RandomLen + 1) +
                                  3 * (WriteTimeout + 2) + HoldLen + ReleaseLen +
                                  6 * AckTimeout + 200;

  logic               clk_i;
  logic               rst_ni;
  logic               rst_lc_ni;
  lc_tx_t             lc_hw_debug_en_i;
  lc_tx_t             lc_dft_en_i;
  mubi8_t             otp_dis_late_debug_i;
  logic               late_debug_wr_valid_i;
  mubi32_t            late_debug_wr_data_i;
  logic               late_debug_wr_lock_i;
  logic               late_debug_wr_ready_o;
  mubi32_t            late_debug_en_o;
  logic               ndmreset_req_i;
  logic [NrHarts-1:0] debug_req_i;
  logic               ndmreset_req_o;
  logic [NrHarts-1:0] debug_req_o;
  logic               ndmreset_ack_o;

  // Reference state of the late-debug register
  mubi32_t     model_late_debug;
  logic [31:0] rng_state;
  int          error_count;
  int          test_count;
  int          failed_tests;
  int          test_start_errors;

  rv_dm_gate i_rv_dm_gate (
    .clk_i,
    .rst_ni,
    .rst_lc_ni,
    .lc_hw_debug_en_i,
    .lc_dft_en_i,
    .otp_dis_late_debug_i,
    .late_debug_wr_valid_i,
    .late_debug_wr_data_i,
    .late_debug_wr_lock_i,
    .late_debug_wr_ready_o,
    .late_debug_en_o,
    .ndmreset_req_i,
    .debug_req_i,
    .ndmreset_req_o,
    .debug_req_o,
    .ndmreset_ack_o
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    #(ClkPeriod * WatchdogCycles);
    $display("Watchdog expired after %0d cycles, run stopped", WatchdogCycles);
    $display("TB FAILED");
    $finish;
  end

  ////////////////////
  // Concurrent checks
  ////////////////////

  // Locked register never moves
  lock_holds_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !late_debug_wr_ready_o |=> $stable(late_debug_en_o))
    else begin
      $display("Error: late_debug_en_o changed to %h while locked", late_debug_en_o);
      error_count++;
    end

  // Ack only once the request is released
  ack_after_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ndmreset_ack_o |-> !ndmreset_req_i)
    else begin
      $display("Error: ndmreset_ack_o = 1 while ndmreset_req_i = 1");
      error_count++;
    end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Debug enable is picked by OTP or register on exact true codes
  function automatic logic expected_gate_open();
    logic use_debug;
    use_debug = (otp_dis_late_debug_i == Mubi8True) || (model_late_debug == Mubi32True);
    if (use_debug) begin
      return lc_hw_debug_en_i == LcTxOn;
    end
    return lc_dft_en_i == LcTxOn;
  endfunction

  task automatic check_gating();
    logic               open;
    logic [NrHarts-1:0] exp_dbg;
    logic               exp_ndm;
    open    = expected_gate_open();
    exp_dbg = open ? debug_req_i : '0;
    exp_ndm = ndmreset_req_i & open;
    assert (debug_req_o === exp_dbg) else begin
      $display("Error: debug_req_o = %h, expected %h", debug_req_o, exp_dbg);
      error_count++;
    end
    assert (ndmreset_req_o === exp_ndm) else begin
      $display("Error: ndmreset_req_o = %h, expected %h", ndmreset_req_o, exp_ndm);
      error_count++;
    end
  endtask

  task automatic set_enables(lc_tx_t hw, lc_tx_t dft, mubi8_t otp);
    @(negedge clk_i);
    lc_hw_debug_en_i     = hw;
    lc_dft_en_i          = dft;
    otp_dis_late_debug_i = otp;
    // Two sync stages plus the selection register
    repeat (SettleLen) @(negedge clk_i);
  endtask

  // Drive at a falling edge and check one cycle later before the next drive
  task automatic run_random_requests(int count);
    repeat (count) begin
      rng_state      = xorshift(rng_state);
      debug_req_i    = rng_state[NrHarts-1:0];
      ndmreset_req_i = rng_state[16];
      @(negedge clk_i);
      check_gating();
    end
    debug_req_i    = '0;
    ndmreset_req_i = 1'b0;
  endtask

  task automatic write_late_debug(mubi32_t data, logic lock);
    int   waited;
    logic accepted;
    waited = 0;
    @(negedge clk_i);
    late_debug_wr_valid_i = 1'b1;
    late_debug_wr_data_i  = data;
    late_debug_wr_lock_i  = lock;
    while (!late_debug_wr_ready_o && waited < WriteTimeout) begin
      @(negedge clk_i);
      waited++;
    end
    accepted = late_debug_wr_ready_o;
    @(negedge clk_i);
    late_debug_wr_valid_i = 1'b0;
    late_debug_wr_lock_i  = 1'b0;
    if (accepted) begin
      model_late_debug = data;
    end else begin
      $display("Write of %h was not accepted within %0d cycles", data, WriteTimeout);
      error_count++;
    end
    assert (late_debug_en_o === model_late_debug) else begin
      $display("Error: late_debug_en_o = %h, expected %h", late_debug_en_o, model_late_debug);
      error_count++;
    end
  endtask

  // Keeps valid high against a locked port
  task automatic hold_write(mubi32_t data, int cycles);
    @(negedge clk_i);
    late_debug_wr_valid_i = 1'b1;
    late_debug_wr_data_i  = data;
    repeat (cycles) begin
      assert (late_debug_wr_ready_o === 1'b0) else begin
        $display("Error: late_debug_wr_ready_o = %h, expected 0", late_debug_wr_ready_o);
        error_count++;
      end
      @(negedge clk_i);
      assert (late_debug_en_o === model_late_debug) else begin
        $display("Error: late_debug_en_o = %h, expected %h", late_debug_en_o, model_late_debug);
        error_count++;
      end
    end
    late_debug_wr_valid_i = 1'b0;
  endtask

  task automatic pulse_lc_reset();
    @(negedge clk_i);
    rst_lc_ni = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_lc_ni = 1'b1;
  endtask

  // Ack must rise within the limit and be gone one cycle later
  // Sampled a quarter period after each falling edge, where the ack is stable
  task automatic expect_ack_pulse(int limit);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < limit) begin
      #(ClkPeriod / 4);
      seen = ndmreset_ack_o;
      waited++;
      if (!seen) begin
        @(negedge clk_i);
      end
    end
    if (!seen) begin
      $display("ndmreset_ack_o did not rise within %0d cycles", limit);
      error_count++;
    end
    @(negedge clk_i);
    #(ClkPeriod / 4);
    assert (ndmreset_ack_o === 1'b0) else begin
      $display("Error: ndmreset_ack_o = %h, expected 0", ndmreset_ack_o);
      error_count++;
    end
  endtask

  task automatic expect_no_ack(int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      assert (ndmreset_ack_o === 1'b0) else begin
        $display("Error: ndmreset_ack_o = %h, expected 0", ndmreset_ack_o);
        error_count++;
      end
    end
  endtask

  task automatic start_test();
    test_start_errors = error_count;
  endtask

  task automatic end_test(string name);
    test_count++;
    if (error_count == test_start_errors) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
    end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_ni                = 1'b0;
    rst_lc_ni             = 1'b0;
    lc_hw_debug_en_i      = LcTxOff;
    lc_dft_en_i           = LcTxOff;
    otp_dis_late_debug_i  = Mubi8False;
    late_debug_wr_valid_i = 1'b0;
    late_debug_wr_data_i  = '0;
    late_debug_wr_lock_i  = 1'b0;
    ndmreset_req_i        = 1'b0;
    debug_req_i           = '0;
    model_late_debug      = Mubi32False;
    rng_state             = 32'hf514_45a2;
    error_count           = 0;
    test_count            = 0;
    failed_tests          = 0;
    test_start_errors     = 0;

    repeat (ResetCycles) @(negedge clk_i);
    rst_ni    = 1'b1;
    rst_lc_ni = 1'b1;

    // Outputs quiet with the port ready and the register disabled
    start_test();
    @(negedge clk_i);
    assert (late_debug_wr_ready_o === 1'b1 && late_debug_en_o === Mubi32False) else begin
      $display("Error: late_debug_wr_ready_o = %h, late_debug_en_o = %h",
               late_debug_wr_ready_o, late_debug_en_o);
      error_count++;
    end
    assert (ndmreset_ack_o === 1'b0) else begin
      $display("Error: ndmreset_ack_o = %h, expected 0", ndmreset_ack_o);
      error_count++;
    end
    check_gating();
    end_test("after reset");

    // OTP forces the debug enable while DFT is held on to tell them apart
    start_test();
    set_enables(LcTxOn, LcTxOff, Mubi8True);
    run_random_requests(RandomLen);
    set_enables(4'hB, LcTxOn, Mubi8True);
    run_random_requests(RandomLen);
    set_enables(LcTxOff, LcTxOn, Mubi8True);
    run_random_requests(RandomLen);
    end_test("enable selection");

    // Register decides once OTP is off
    start_test();
    set_enables(LcTxOff, LcTxOn, Mubi8False);
    run_random_requests(RandomLen);
    set_enables(LcTxOn, LcTxOff, Mubi8False);
    run_random_requests(RandomLen);
    write_late_debug(Mubi32True, 1'b0);
    repeat (SettleLen) @(negedge clk_i);
    run_random_requests(RandomLen);
    end_test("late-debug selection");

    // Locking a near-miss value hands control back to the DFT enable
    start_test();
    write_late_debug(32'h1234_5678, 1'b1);
    hold_write(Mubi32True, HoldLen);
    repeat (SettleLen) @(negedge clk_i);
    run_random_requests(RandomLen);
    end_test("write lock");

    // Request and life-cycle reset, then release of both
    start_test();
    set_enables(LcTxOff, LcTxOn, Mubi8False);
    @(negedge clk_i);
    ndmreset_req_i = 1'b1;
    repeat (2) @(negedge clk_i);
    pulse_lc_reset();
    // Request still held well after the life-cycle reset has released
    expect_no_ack(ReleaseLen);
    ndmreset_req_i = 1'b0;
    expect_ack_pulse(AckTimeout);
    // Without a life-cycle reset no ack follows
    @(negedge clk_i);
    ndmreset_req_i = 1'b1;
    repeat (4) @(negedge clk_i);
    ndmreset_req_i = 1'b0;
    expect_no_ack(AckTimeout);
    // Reset enable off holds the ack back
    set_enables(LcTxOff, LcTxOff, Mubi8False);
    @(negedge clk_i);
    ndmreset_req_i = 1'b1;
    pulse_lc_reset();
    @(negedge clk_i);
    ndmreset_req_i = 1'b0;
    expect_no_ack(AckTimeout);
    @(negedge clk_i);
    lc_dft_en_i = LcTxOn;
    expect_ack_pulse(AckTimeout);
    end_test("ndm acknowledge");

    $display("Tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/rv_dm_gate.sv
////////////////////
// Debug-enable gate top level
// Synchronizes the life-cycle and OTP enables, holds the late-debug register,
// gates the debug core requests and tracks NDM reset completion
////////////////////

`default_nettype none

module rv_dm_gate
  import rv_dm_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // Life-cycle reset, asynchronous and active low
  input  wire logic               rst_lc_ni,
  // Enables from life cycle and OTP
  input  wire lc_tx_t             lc_hw_debug_en_i,
  input  wire lc_tx_t             lc_dft_en_i,
  input  wire mubi8_t             otp_dis_late_debug_i,
  // Late-debug register write port
  input  wire logic               late_debug_wr_valid_i,
  input  wire mubi32_t            late_debug_wr_data_i,
  input  wire logic               late_debug_wr_lock_i,
  output logic                    late_debug_wr_ready_o,
  output mubi32_t                 late_debug_en_o,
  // Debug core side
  input  wire logic               ndmreset_req_i,
  input  wire logic [NrHarts-1:0] debug_req_i,
  output logic                    ndmreset_req_o,
  output logic [NrHarts-1:0]      debug_req_o,
  output logic                    ndmreset_ack_o
);

  lc_tx_t  lc_hw_debug_en;
  lc_tx_t  lc_dft_en;
  mubi8_t  otp_dis_late_debug;
  mubi32_t late_debug_en;
  logic    lc_rst_asserted_async;
  logic    lc_rst_asserted;
  logic    reset_req_en;

  ////////////////////
  // Synchronizers
  ////////////////////

  rv_dm_sync #(
    .T         (lc_tx_t),
    .ResetValue(LcTxOff)
  ) u_sync_hw_debug (
    .clk_i,
    .rst_ni,
    .d_i   (lc_hw_debug_en_i),
    .q_o   (lc_hw_debug_en)
  );

  rv_dm_sync #(
    .T         (lc_tx_t),
    .ResetValue(LcTxOff)
  ) u_sync_dft (
    .clk_i,
    .rst_ni,
    .d_i   (lc_dft_en_i),
    .q_o   (lc_dft_en)
  );

  rv_dm_sync #(
    .T         (mubi8_t),
    .ResetValue(Mubi8False)
  ) u_sync_otp (
    .clk_i,
    .rst_ni,
    .d_i   (otp_dis_late_debug_i),
    .q_o   (otp_dis_late_debug)
  );

  // Flops held at 1 by the life-cycle reset, shifting in 0 once it releases
  rv_dm_sync #(
    .T         (logic),
    .ResetValue(1'b1)
  ) u_sync_lc_rst_async (
    .clk_i,
    .rst_ni(rst_lc_ni),
    .d_i   (1'b0),
    .q_o   (lc_rst_asserted_async)
  );

  // Reset status brought back under rst_ni
  rv_dm_sync #(
    .T         (logic),
    .ResetValue(1'b0)
  ) u_sync_lc_rst (
    .clk_i,
    .rst_ni,
    .d_i   (lc_rst_asserted_async),
    .q_o   (lc_rst_asserted)
  );

  ////////////////////
  // Register, control and tracking
  ////////////////////

  rv_dm_late_debug_reg u_late_debug_reg (
    .clk_i,
    .rst_ni,
    .wr_valid_i     (late_debug_wr_valid_i),
    .wr_data_i      (late_debug_wr_data_i),
    .wr_lock_i      (late_debug_wr_lock_i),
    .wr_ready_o     (late_debug_wr_ready_o),
    .late_debug_en_o(late_debug_en)
  );

  rv_dm_en_ctrl u_en_ctrl (
    .clk_i,
    .rst_ni,
    .lc_hw_debug_en_i    (lc_hw_debug_en),
    .lc_dft_en_i         (lc_dft_en),
    .otp_dis_late_debug_i(otp_dis_late_debug),
    .late_debug_en_i     (late_debug_en),
    .ndmreset_req_i,
    .debug_req_i,
    .ndmreset_req_o,
    .debug_req_o,
    .reset_req_en_o      (reset_req_en)
  );

  // Tracker sees the raw request, not the gated one
  rv_dm_ndm_tracker u_ndm_tracker (
    .clk_i,
    .rst_ni,
    .ndmreset_req_i,
    .lc_rst_asserted_i(lc_rst_asserted),
    .reset_req_en_i   (reset_req_en),
    .ndmreset_ack_o
  );

  assign late_debug_en_o = late_debug_en;

endmodule

`default_nettype wire

//--- hdl/rv_dm_ndm_tracker.sv
////////////////////
// NDM reset acknowledge tracking
// Waits for a request, a life-cycle reset seen during it,
// and then the release of both before acknowledging
////////////////////

`default_nettype none

module rv_dm_ndm_tracker (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  // Raw NDM reset request from the debug core
  input  wire logic ndmreset_req_i,
  // Life-cycle reset status, synchronized to clk_i
  input  wire logic lc_rst_asserted_i,
  // Reset requests currently allowed
  input  wire logic reset_req_en_i,
  // Completion pulse back to the debug core
  output logic      ndmreset_ack_o
);

  logic ndmreset_pending_q;
  logic lc_rst_pending_q;
  logic ndmreset_ack;

  ////////////////////
  // Pending state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ndmreset_pending_q <= 1'b0;
      lc_rst_pending_q   <= 1'b0;
    end else begin
      // New request only while idle
      if (ndmreset_req_i && !ndmreset_pending_q) begin
        ndmreset_pending_q <= 1'b1;
      end else if (ndmreset_ack) begin
        ndmreset_pending_q <= 1'b0;
      end
      // Only count a life-cycle reset seen during a pending request
      if (ndmreset_pending_q && lc_rst_asserted_i) begin
        lc_rst_pending_q <= 1'b1;
      end else if (ndmreset_ack) begin
        lc_rst_pending_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // Acknowledge
  ////////////////////

  // Request done and reset released, while the gate is open
  assign ndmreset_ack = ndmreset_pending_q &
                        lc_rst_pending_q &
                        ~ndmreset_req_i &
                        ~lc_rst_asserted_i &
                        reset_req_en_i;

  assign ndmreset_ack_o = ndmreset_ack;

endmodule

`default_nettype wire

//--- hdl/rv_dm_en_ctrl.sv
////////////////////
// Enable selection and request gating
// Picks the debug or DFT life-cycle enable from the OTP and register words
// Registers the pick, then gates the NDM reset and per-hart debug requests
////////////////////

`default_nettype none

module rv_dm_en_ctrl
  import rv_dm_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // Synchronized enables
  input  wire lc_tx_t             lc_hw_debug_en_i,
  input  wire lc_tx_t             lc_dft_en_i,
  input  wire mubi8_t             otp_dis_late_debug_i,
  input  wire mubi32_t            late_debug_en_i,
  // Requests from the debug core
  input  wire logic               ndmreset_req_i,
  input  wire logic [NrHarts-1:0] debug_req_i,
  // Gated requests towards the chip
  output logic                    ndmreset_req_o,
  output logic [NrHarts-1:0]      debug_req_o,
  // Reset request enable for the tracker
  output logic                    reset_req_en_o
);

  logic               use_hw_debug;
  lc_tx_t             en_sel_d;
  lc_tx_t             en_sel_q;
  logic               reset_req_en;
  logic [NrHarts-1:0] debug_req_en;

  ////////////////////
  // Selection
  ////////////////////

  // Debug enable is honoured when OTP disables late debug
  // or software has opened the late-debug window
  assign use_hw_debug = mubi8_test_true(otp_dis_late_debug_i) |
                        mubi32_test_true(late_debug_en_i);

  assign en_sel_d = use_hw_debug ? lc_hw_debug_en_i : lc_dft_en_i;

  // Selected word is held as a multi-bit value until decode
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_sel_q <= LcTxOff;
    end else begin
      en_sel_q <= en_sel_d;
    end
  end

  ////////////////////
  // Gating
  ////////////////////

  // Strict decode, near-miss codes stay off
  assign reset_req_en = lc_tx_test_true(en_sel_q);

  for (genvar h = 0; h < NrHarts; h++) begin : gen_hart_en
    assign debug_req_en[h] = lc_tx_test_true(en_sel_q);
  end

  // Requests pass in the same cycle under the registered enable
  assign ndmreset_req_o = ndmreset_req_i & reset_req_en;
  assign debug_req_o    = debug_req_i & debug_req_en;
  assign reset_req_en_o = reset_req_en;

endmodule

`default_nettype wire

//--- hdl/rv_dm_late_debug_reg.sv
////////////////////
// Late-debug-enable register with a sticky write lock
// Written over a valid/ready port, a write with wr_lock_i set locks it
// Once locked, ready stays low until the next rst_ni
////////////////////

`default_nettype none

module rv_dm_late_debug_reg
  import rv_dm_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  // Write port
  input  wire logic    wr_valid_i,
  input  wire mubi32_t wr_data_i,
  input  wire logic    wr_lock_i,
  output logic         wr_ready_o,
  // Current register value
  output mubi32_t      late_debug_en_o
);

  mubi32_t value_q;
  logic    lock_q;
  logic    wr_fire;

  // Lock flag is the only source of back-pressure
  assign wr_ready_o = ~lock_q;
  assign wr_fire    = wr_valid_i & wr_ready_o;

  // Register starts out disabled so the DFT enable is selected
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      value_q <= Mubi32False;
      lock_q  <= 1'b0;
    end else if (wr_fire) begin
      value_q <= wr_data_i;
      // Lock is sticky, only reset clears it
      if (wr_lock_i) begin
        lock_q <= 1'b1;
      end
    end
  end

  assign late_debug_en_o = value_q;

endmodule

`default_nettype wire

//--- hdl/rv_dm_sync.sv
////////////////////
// Two-flop synchronizer for any packed payload type
// Both stages reset asynchronously to ResetValue
// Output follows the input two rising clock edges later
////////////////////

`default_nettype none

module rv_dm_sync #(
  parameter type T          = logic,
  parameter T    ResetValue = T'(0)
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire T     d_i,
  output T          q_o
);

  // First stage may go metastable on an asynchronous input
  T stage1_q;
  T stage2_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage1_q <= ResetValue;
      stage2_q <= ResetValue;
    end else begin
      stage1_q <= d_i;
      stage2_q <= stage1_q;
    end
  end

  assign q_o = stage2_q;

endmodule

`default_nettype wire

//--- hdl/rv_dm_pkg.sv
////////////////////
// Shared encodings for the debug-enable gate and the NDM reset tracker
// Multi-bit life-cycle, OTP and register words plus their strict decoders
// Imported by wildcard wherever one of these types or functions is needed
////////////////////

`default_nettype none

package rv_dm_pkg;

  // Word widths
  localparam int LcTxWidth   = 4;
  localparam int Mubi8Width  = 8;
  localparam int Mubi32Width = 32;

  // Number of harts behind the debug module
  localparam int NrHarts = 2;

  // Life-cycle enable word
  typedef logic [LcTxWidth-1:0] lc_tx_t;
  localparam lc_tx_t LcTxOn  = 4'hA;
  localparam lc_tx_t LcTxOff = 4'h5;

  // OTP multi-bit boolean
  typedef logic [Mubi8Width-1:0] mubi8_t;
  localparam mubi8_t Mubi8True  = 8'h96;
  localparam mubi8_t Mubi8False = 8'h69;

  // Late-debug-enable register word
  typedef logic [Mubi32Width-1:0] mubi32_t;
  localparam mubi32_t Mubi32True  = 32'h9696_9696;
  localparam mubi32_t Mubi32False = 32'h6969_6969;

  // Strict decoders, any value other than the exact true code is false
  function automatic logic lc_tx_test_true(lc_tx_t val);
    return val == LcTxOn;
  endfunction

  function automatic logic mubi8_test_true(mubi8_t val);
    return val == Mubi8True;
  endfunction

  function automatic logic mubi32_test_true(mubi32_t val);
    return val == Mubi32True;
  endfunction

endpackage

`default_nettype wire
